//--- flist.f
src/glbl_reg_pkg.sv
src/bist_pkg.sv
src/cfg_bus_if.sv
src/ser_req_if.sv
src/reg_front.sv
src/bist_cfg_regs.sv
src/bist_serial_port.sv
src/glbl_cfg_top.sv
sim/bist_chain_model.sv
sim/tb_glbl_cfg_top.sv

//--- sim/bist_chain_model.sv
`timescale 1ns/1ps

module bist_chain_model (
    input  logic                          mclk,
    input  logic                          reset_n,
    input  logic [bist_pkg::bist_num-1:0] shift,
    input  logic [bist_pkg::bist_num-1:0] sdi,
    output logic [bist_pkg::bist_num-1:0] sdo
);
    import glbl_reg_pkg::*;
    import bist_pkg::*;

    // One serial chain per engine
    logic [ser_len-1:0] chain [bist_num];

    // New bit enters at the top, chain moves right
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            for (int e = 0; e < bist_num; e++) begin
                chain[e] <= '0;
            end
        end else begin
            for (int e = 0; e < bist_num; e++) begin
                if (shift[e]) begin
                    chain[e] <= {sdi[e], chain[e][ser_len-1:1]};
                end
            end
        end
    end

    // Bit 0 leaves first
    always_comb begin
        for (int e = 0; e < bist_num; e++) begin
            sdo[e] = chain[e][0];
        end
    end

endmodule

//--- sim/tb_glbl_cfg_top.sv
`timescale 1ns/1ps

module tb_glbl_cfg_top;
    import glbl_reg_pkg::*;
    import bist_pkg::*;

    logic                                mclk;
    logic                                reset_n;
    logic                                reg_cs;
    logic                                reg_wr;
    logic [reg_addr_w-1:0]               reg_addr;
    logic [reg_data_w-1:0]               reg_wdata;
    logic [reg_be_w-1:0]                 reg_be;
    logic [reg_data_w-1:0]               reg_rdata;
    logic                                reg_ack;
    logic [bist_num-1:0]                 bist_en;
    logic [bist_num-1:0]                 bist_run;
    logic [bist_num-1:0]                 bist_load;
    logic [bist_num-1:0]                 bist_sdi;
    logic [bist_num-1:0]                 bist_shift;
    logic [bist_num-1:0]                 bist_sdo;
    logic [bist_num-1:0]                 bist_done;
    logic [bist_num-1:0]                 bist_error;
    logic [bist_num-1:0]                 bist_correct;
    logic [bist_num-1:0][bist_cnt_w-1:0] bist_error_cnt;

    int value_errs;
    int other_errs;
    // Shift cycles seen per engine
    int shift_cnt [bist_num];

    glbl_cfg_top glbl_cfg_top_i (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .reg_cs         (reg_cs),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_be         (reg_be),
        .reg_rdata      (reg_rdata),
        .reg_ack        (reg_ack),
        .bist_en        (bist_en),
        .bist_run       (bist_run),
        .bist_load      (bist_load),
        .bist_sdi       (bist_sdi),
        .bist_shift     (bist_shift),
        .bist_sdo       (bist_sdo),
        .bist_done      (bist_done),
        .bist_error     (bist_error),
        .bist_correct   (bist_correct),
        .bist_error_cnt (bist_error_cnt)
    );

    bist_chain_model chains (
        .mclk    (mclk),
        .reset_n (reset_n),
        .shift   (bist_shift),
        .sdi     (bist_sdi),
        .sdo     (bist_sdo)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    // --------------------------------------------------
    // Protocol assertions
    // --------------------------------------------------
    ack_one_cycle: assert property (@(posedge mclk) disable iff (!reset_n)
        reg_ack |=> !reg_ack)
        else note_failure("reg_ack stayed high for more than one cycle");

    // At most one chain shifts at a time
    shift_onehot: assert property (@(posedge mclk) disable iff (!reset_n)
        $onehot0(bist_shift))
        else note_failure("more than one bist_shift bit high");

    sdi_needs_shift: assert property (@(posedge mclk) disable iff (!reset_n)
        (bist_sdi & ~bist_shift) == '0)
        else note_failure("bist_sdi high on an engine that is not shifting");

    always @(negedge mclk) begin
        for (int e = 0; e < bist_num; e++) begin
            if (bist_shift[e]) begin
                shift_cnt[e]++;
            end
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic note_failure(input string what);
        other_errs++;
        $display("Failure: %s at %0t", what, $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp)
            else begin
                value_errs++;
                $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            end
    endtask

    task automatic end_run();
        $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // One bus access that returns on the falling edge seeing reg_ack
    task automatic bus_access(input logic wr, input logic [3:0] word,
            input logic [31:0] wdata, input logic [3:0] be, output logic [31:0] rdata);
        int   waited;
        logic serial;
        serial = (wr && word == addr_ser_write) || (!wr && word == addr_ser_read);
        waited = 0;
        // Leaves cs low for a full cycle after the last access
        @(negedge mclk);
        reg_cs    = 1'b1;
        reg_wr    = wr;
        reg_addr  = {2'b00, word, 2'b00};
        reg_wdata = wdata;
        reg_be    = be;
        do begin
            @(negedge mclk);
            waited++;
        end while (!reg_ack && waited < 4 * ser_len);
        if (!reg_ack) begin
            note_failure($sformatf("no reg_ack for access to word %0d", word));
            end_run();
        end else begin
            rdata  = reg_rdata;
            reg_cs = 1'b0;
            reg_wr = 1'b0;
            // Ack one edge after cs is first sampled
            if (!serial) begin
                check_value("reg_ack latency", 32'(waited), 32'd2);
            end
        end
    endtask

    task automatic bus_write(input logic [3:0] word, input logic [31:0] data,
            input logic [3:0] be);
        logic [31:0] unused;
        bus_access(1'b1, word, data, be, unused);
    endtask

    task automatic bus_read(input logic [3:0] word, output logic [31:0] data);
        bus_access(1'b0, word, 32'h0, 4'h0, data);
    endtask

    task automatic clear_shifts();
        for (int e = 0; e < bist_num; e++) begin
            shift_cnt[e] = 0;
        end
    endtask

    // Only engine k shifts, for one word
    task automatic check_shifts(input int k);
        for (int e = 0; e < bist_num; e++) begin
            check_value($sformatf("bist_shift[%0d] cycles", e), 32'(shift_cnt[e]),
                (e == k) ? 32'(ser_len) : 32'd0);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
            input logic [31:0] new_w, input logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Status byte holds done, error, correct, zero and the count
    function automatic logic [31:0] pack_status(input int first);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 4; i++) begin
            word[8*i]        = bist_done[first+i];
            word[8*i+1]      = bist_error[first+i];
            word[8*i+2]      = bist_correct[first+i];
            word[8*i+4 +: 4] = bist_error_cnt[first+i];
        end
        return word;
    endfunction

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin : stimulus
        logic [31:0] rd;
        logic [31:0] wd;
        logic [31:0] ctrl_exp;
        logic [3:0]  be;
        value_errs     = 0;
        other_errs     = 0;
        ctrl_exp       = '0;
        reset_n        = 1'b0;
        reg_cs         = 1'b0;
        reg_wr         = 1'b0;
        reg_addr       = '0;
        reg_wdata      = '0;
        reg_be         = '0;
        bist_done      = '0;
        bist_error     = '0;
        bist_correct   = '0;
        bist_error_cnt = '0;
        clear_shifts();
        void'($urandom(8));
        repeat (3) @(negedge mclk);
        reset_n = 1'b1;

        // Reset state
        check_value("reg_ack", 32'(reg_ack), 32'h0);
        check_value("bist_en", 32'(bist_en), 32'h0);
        check_value("bist_run", 32'(bist_run), 32'h0);
        check_value("bist_load", 32'(bist_load), 32'h0);
        check_value("bist_shift", 32'(bist_shift), 32'h0);
        check_value("bist_sdi", 32'(bist_sdi), 32'h0);
        bus_read(addr_serial_sel, rd);
        check_value("serial select", rd, 32'h0);
        bus_read(addr_bist_ctrl, rd);
        check_value("control word", rd, 32'h0);

        // Control word byte merge and nibble fan-out
        repeat (8) begin
            wd = $urandom;
            be = 4'($urandom);
            ctrl_exp = merge_bytes(ctrl_exp, wd, be);
            bus_write(addr_bist_ctrl, wd, be);
            bus_read(addr_bist_ctrl, rd);
            check_value("control word", rd, ctrl_exp);
            for (int e = 0; e < bist_num; e++) begin
                check_value($sformatf("bist_en[%0d]", e), 32'(bist_en[e]),
                    32'(ctrl_exp[4*e]));
                check_value($sformatf("bist_run[%0d]", e), 32'(bist_run[e]),
                    32'(ctrl_exp[4*e+1]));
                check_value($sformatf("bist_load[%0d]", e), 32'(bist_load[e]),
                    32'(ctrl_exp[4*e+2]));
            end
        end

        // Status words
        repeat (4) begin
            @(negedge mclk);
            bist_done      = 8'($urandom);
            bist_error     = 8'($urandom);
            bist_correct   = 8'($urandom);
            bist_error_cnt = $urandom;
            bus_read(addr_bist_stat_lo, rd);
            check_value("status low word", rd, pack_status(0));
            bus_read(addr_bist_stat_hi, rd);
            check_value("status high word", rd, pack_status(4));
        end

        // Unused words read zero and ignore writes
        bus_write(4'd0, 32'hffff_ffff, 4'hf);
        bus_read(4'd0, rd);
        check_value("unused word 0", rd, 32'h0);
        bus_read(4'd9, rd);
        check_value("unused word 9", rd, 32'h0);
        bus_read(4'd15, rd);
        check_value("unused word 15", rd, 32'h0);
        bus_read(addr_bist_ctrl, rd);
        check_value("control word", rd, ctrl_exp);

        // Serial loop through each chain
        for (int k = 0; k < bist_num; k++) begin
            wd = $urandom;
            bus_write(addr_serial_sel, 32'(k), 4'b0001);
            bus_read(addr_serial_sel, rd);
            check_value("serial select", rd, 32'(k));
            clear_shifts();
            bus_write(addr_ser_write, wd, 4'hf);
            check_shifts(k);
            // LSB goes out first, so the chain holds the word unchanged
            check_value($sformatf("chain[%0d] after write", k), chains.chain[k], wd);
            clear_shifts();
            bus_read(addr_ser_read, rd);
            check_value("serial read word", rd, wd);
            check_shifts(k);
            // Reads push zeros in
            check_value($sformatf("chain[%0d] after read", k), chains.chain[k], 32'h0);
            bus_read(addr_ser_last, rd);
            check_value("last shift word", rd, wd);
        end

        // Selects past the last engine
        repeat (3) begin
            bus_write(addr_serial_sel, 32'(8 + $urandom_range(7, 0)), 4'b0001);
            clear_shifts();
            bus_read(addr_ser_read, rd);
            check_value("serial read, no engine", rd, 32'h0);
            check_shifts(-1);
        end

        end_run();
    end

endmodule

//--- src/bist_cfg_regs.sv
`timescale 1ns/1ps

module bist_cfg_regs (
    input  logic                                          mclk,
    input  logic                                          reset_n,
    cfg_bus_if.bank                                       bus,
    input  logic [bist_pkg::bist_num-1:0]                 bist_done,
    input  logic [bist_pkg::bist_num-1:0]                 bist_error,
    input  logic [bist_pkg::bist_num-1:0]                 bist_correct,
    input  logic [bist_pkg::bist_num-1:0][bist_pkg::bist_cnt_w-1:0] bist_error_cnt,
    output logic [bist_pkg::bist_num-1:0]                 bist_en,
    output logic [bist_pkg::bist_num-1:0]                 bist_run,
    output logic [bist_pkg::bist_num-1:0]                 bist_load,
    output logic [bist_pkg::bist_sel_w-1:0]               chain_sel
);
    import glbl_reg_pkg::*;
    import bist_pkg::*;

    bist_ctrl_word_u            ctrl_q;
    logic [7:0]                 sel_q;
    bist_stat_t [bist_num-1:0]  stat;

    // --------------------------------------------------
    // Control and select registers
    // --------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q <= '0;
            sel_q  <= '0;
        end else if (bus.wr_en) begin
            // Byte lanes merge into the control word
            if (bus.word_addr == addr_bist_ctrl) begin
                for (int b = 0; b < reg_be_w; b++) begin
                    if (bus.be[b]) begin
                        ctrl_q.bytes[b] <= bus.wdata[8*b +: 8];
                    end
                end
            end
            // Select is a single byte
            if (bus.word_addr == addr_serial_sel && bus.be[0]) begin
                sel_q <= bus.wdata[7:0];
            end
        end
    end

    assign chain_sel = sel_q[bist_sel_w-1:0];

    // Engine nibble fan-out
    always_comb begin
        for (int e = 0; e < bist_num; e++) begin
            bist_en[e]   = ctrl_q.engine[e].en;
            bist_run[e]  = ctrl_q.engine[e].run;
            bist_load[e] = ctrl_q.engine[e].load;
        end
    end

    // --------------------------------------------------
    // Status packing
    // --------------------------------------------------
    always_comb begin
        for (int e = 0; e < bist_num; e++) begin
            stat[e].done    = bist_done[e];
            stat[e].error   = bist_error[e];
            stat[e].correct = bist_correct[e];
            stat[e].zero    = 1'b0;
            stat[e].err_cnt = bist_error_cnt[e];
        end
    end

    // Read mux, unmapped words give zero
    always_comb begin
        case (bus.word_addr)
            addr_serial_sel:   bus.rdata = {{(reg_data_w-8){1'b0}}, sel_q};
            addr_bist_ctrl:    bus.rdata = ctrl_q;
            addr_bist_stat_lo: bus.rdata = stat[bist_num/2-1:0];
            addr_bist_stat_hi: bus.rdata = stat[bist_num-1:bist_num/2];
            default:           bus.rdata = '0;
        endcase
    end

endmodule

//--- src/bist_pkg.sv
package bist_pkg;

    // Number of memory BIST engines
    localparam int bist_num   = 8;
    // Chain select and error count widths
    localparam int bist_sel_w = 4;
    localparam int bist_cnt_w = 4;

    // --------------------------------------------------
    // Per-engine control nibble, en in bit 0
    // --------------------------------------------------
    typedef struct packed {
        logic spare;
        logic load;
        logic run;
        logic en;
    } bist_ctrl_t;

    // Control word seen as bytes or as engine nibbles
    typedef union packed {
        logic [3:0][7:0]            bytes;
        bist_ctrl_t [bist_num-1:0]  engine;
    } bist_ctrl_word_u;

    // Per-engine status byte, done in bit 0
    typedef struct packed {
        logic [bist_cnt_w-1:0] err_cnt;
        logic                  zero;
        logic                  correct;
        logic                  error;
        logic                  done;
    } bist_stat_t;

endpackage

//--- src/bist_serial_port.sv
`timescale 1ns/1ps

module bist_serial_port (
    input  logic                            mclk,
    input  logic                            reset_n,
    ser_req_if.port                         ser,
    input  logic [bist_pkg::bist_sel_w-1:0] chain_sel,
    input  logic [bist_pkg::bist_num-1:0]   bist_sdo,
    output logic [bist_pkg::bist_num-1:0]   bist_sdi,
    output logic [bist_pkg::bist_num-1:0]   bist_shift
);
    import glbl_reg_pkg::*;
    import bist_pkg::*;

    logic                       shift_en;
    logic [$clog2(ser_len)-1:0] bit_cnt;
    logic                       done_q;
    logic [reg_data_w-1:0]      tx_q;
    logic [reg_data_w-1:0]      rx_q;
    logic [reg_data_w-1:0]      shadow_q;
    logic [bist_num-1:0]        sel_hit;
    logic                       sdo_sel;

    // --------------------------------------------------
    // Shift sequencing
    // --------------------------------------------------
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            shift_en <= 1'b0;
            bit_cnt  <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (ser.start_wr || ser.start_rd) begin
                shift_en <= 1'b1;
                bit_cnt  <= '0;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
                // Last bit of the word
                if (bit_cnt == ($clog2(ser_len))'(ser_len - 1)) begin
                    shift_en <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

    // Data path, LSB first out, new bits enter at the top
    always_ff @(posedge mclk) begin
        if (ser.start_wr) begin
            tx_q <= ser.wdata;
        end else if (ser.start_rd) begin
            // Reads push zeros into the chain
            tx_q <= '0;
        end else if (shift_en) begin
            tx_q <= tx_q >> 1;
            rx_q <= {sdo_sel, rx_q[reg_data_w-1:1]};
            if (bit_cnt == ($clog2(ser_len))'(ser_len - 1)) begin
                shadow_q <= {sdo_sel, rx_q[reg_data_w-1:1]};
            end
        end
    end

    assign ser.done  = done_q;
    assign ser.rdata = shadow_q;

    // --------------------------------------------------
    // Engine routing
    // --------------------------------------------------
    always_comb begin
        sdo_sel = 1'b0;
        for (int e = 0; e < bist_num; e++) begin
            sel_hit[e] = (chain_sel == bist_sel_w'(e));
            if (sel_hit[e]) begin
                sdo_sel = bist_sdo[e];
            end
        end
    end

    // Selects 8 and up reach no engine
    assign bist_shift = sel_hit & {bist_num{shift_en}};
    assign bist_sdi   = sel_hit & {bist_num{shift_en & tx_q[0]}};

endmodule

//--- src/cfg_bus_if.sv
`timescale 1ns/1ps

interface cfg_bus_if;
    import glbl_reg_pkg::*;

    // Write strobe, one cycle
    logic                  wr_en;
    logic [reg_word_w-1:0] word_addr;
    logic [reg_data_w-1:0] wdata;
    logic [reg_be_w-1:0]   be;
    // Combinational read data for word_addr
    logic [reg_data_w-1:0] rdata;

    modport front (
        output wr_en, word_addr, wdata, be,
        input  rdata
    );

    modport bank (
        input  wr_en, word_addr, wdata, be,
        output rdata
    );

endinterface

//--- src/glbl_cfg_top.sv
`timescale 1ns/1ps

module glbl_cfg_top (
    input  logic                                mclk,
    input  logic                                reset_n,

    // --------------------------------------------------
    // Register bus
    // --------------------------------------------------
    input  logic                                reg_cs,
    input  logic                                reg_wr,
    input  logic [glbl_reg_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [glbl_reg_pkg::reg_data_w-1:0] reg_wdata,
    input  logic [glbl_reg_pkg::reg_be_w-1:0]   reg_be,
    output logic [glbl_reg_pkg::reg_data_w-1:0] reg_rdata,
    output logic                                reg_ack,

    // --------------------------------------------------
    // BIST engines
    // --------------------------------------------------
    output logic [bist_pkg::bist_num-1:0]       bist_en,
    output logic [bist_pkg::bist_num-1:0]       bist_run,
    output logic [bist_pkg::bist_num-1:0]       bist_load,
    output logic [bist_pkg::bist_num-1:0]       bist_sdi,
    output logic [bist_pkg::bist_num-1:0]       bist_shift,
    input  logic [bist_pkg::bist_num-1:0]       bist_sdo,
    input  logic [bist_pkg::bist_num-1:0]       bist_done,
    input  logic [bist_pkg::bist_num-1:0]       bist_error,
    input  logic [bist_pkg::bist_num-1:0]       bist_correct,
    input  logic [bist_pkg::bist_num-1:0][bist_pkg::bist_cnt_w-1:0] bist_error_cnt
);

    logic [bist_pkg::bist_sel_w-1:0] chain_sel;

    cfg_bus_if cfg_bus ();
    ser_req_if ser_req ();

    // Bus decode and reply
    reg_front u_front (
        .mclk      (mclk),
        .reset_n   (reset_n),
        .reg_cs    (reg_cs),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_be    (reg_be),
        .reg_rdata (reg_rdata),
        .reg_ack   (reg_ack),
        .cfg       (cfg_bus.front),
        .ser       (ser_req.front)
    );

    // Control, select and status words
    bist_cfg_regs u_regs (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .bus            (cfg_bus.bank),
        .bist_done      (bist_done),
        .bist_error     (bist_error),
        .bist_correct   (bist_correct),
        .bist_error_cnt (bist_error_cnt),
        .bist_en        (bist_en),
        .bist_run       (bist_run),
        .bist_load      (bist_load),
        .chain_sel      (chain_sel)
    );

    // Serial chain access
    bist_serial_port u_serial (
        .mclk       (mclk),
        .reset_n    (reset_n),
        .ser        (ser_req.port),
        .chain_sel  (chain_sel),
        .bist_sdo   (bist_sdo),
        .bist_sdi   (bist_sdi),
        .bist_shift (bist_shift)
    );

endmodule

//--- src/glbl_reg_pkg.sv
package glbl_reg_pkg;

    // --------------------------------------------------
    // Register bus widths
    // --------------------------------------------------
    localparam int reg_data_w = 32;
    localparam int reg_addr_w = 8;
    localparam int reg_be_w   = 4;

    // Word address taken from byte address bits 5:2
    localparam int reg_word_w = 4;

    // --------------------------------------------------
    // Word address map
    // --------------------------------------------------
    localparam logic [reg_word_w-1:0] addr_serial_sel   = 4'd2;
    localparam logic [reg_word_w-1:0] addr_bist_ctrl    = 4'd3;
    localparam logic [reg_word_w-1:0] addr_bist_stat_lo = 4'd4;
    localparam logic [reg_word_w-1:0] addr_bist_stat_hi = 4'd5;
    localparam logic [reg_word_w-1:0] addr_ser_write    = 4'd6;
    localparam logic [reg_word_w-1:0] addr_ser_read     = 4'd7;
    localparam logic [reg_word_w-1:0] addr_ser_last     = 4'd8;

    // Bits moved per serial transfer
    localparam int ser_len = 32;

endpackage

//--- src/reg_front.sv
`timescale 1ns/1ps

module reg_front (
    input  logic                                mclk,
    input  logic                                reset_n,
    input  logic                                reg_cs,
    input  logic                                reg_wr,
    input  logic [glbl_reg_pkg::reg_addr_w-1:0] reg_addr,
    input  logic [glbl_reg_pkg::reg_data_w-1:0] reg_wdata,
    input  logic [glbl_reg_pkg::reg_be_w-1:0]   reg_be,
    output logic [glbl_reg_pkg::reg_data_w-1:0] reg_rdata,
    output logic                                reg_ack,
    cfg_bus_if.front                            cfg,
    ser_req_if.front                            ser
);
    import glbl_reg_pkg::*;

    logic [reg_word_w-1:0] word_addr;
    logic                  req_q;
    logic                  req_d;
    logic                  req_pedge;
    logic                  ser_wr_hit;
    logic                  ser_rd_hit;
    logic                  ser_acc;
    logic                  last_rd;
    logic                  ack_ser;
    logic                  ack_bank;
    logic [reg_data_w-1:0] rd_mux;

    // --------------------------------------------------
    // Request decode
    // --------------------------------------------------
    assign word_addr  = reg_addr[reg_word_w+1:2];
    assign ser_wr_hit = reg_wr && (word_addr == addr_ser_write);
    assign ser_rd_hit = !reg_wr && (word_addr == addr_ser_read);
    assign ser_acc    = ser_wr_hit || ser_rd_hit;
    // Last shifted word, no new transfer
    assign last_rd    = !reg_wr && (word_addr == addr_ser_last);

    // Request held off while acking, edge gives one access per cs
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            req_q <= 1'b0;
            req_d <= 1'b0;
        end else begin
            req_q <= reg_cs && !reg_ack;
            req_d <= req_q;
        end
    end

    assign req_pedge = req_q && !req_d;

    // Bank side
    assign cfg.wr_en     = req_pedge && reg_wr && !ser_acc;
    assign cfg.word_addr = word_addr;
    assign cfg.wdata     = reg_wdata;
    assign cfg.be        = reg_be;

    // Serial side
    assign ser.start_wr = req_pedge && ser_wr_hit;
    assign ser.start_rd = req_pedge && ser_rd_hit;
    assign ser.wdata    = reg_wdata;

    // --------------------------------------------------
    // Reply
    // --------------------------------------------------
    // Serial access waits for done
    assign ack_ser  = reg_cs && ser_acc && ser.done;
    // Everything else answers one edge later
    assign ack_bank = req_pedge && !ser_acc;
    assign rd_mux   = (ack_ser || last_rd) ? ser.rdata : cfg.rdata;

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= ack_ser || ack_bank;
        end
    end

    always_ff @(posedge mclk) begin
        if (ack_ser || ack_bank) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

//--- src/ser_req_if.sv
`timescale 1ns/1ps

interface ser_req_if;
    import glbl_reg_pkg::*;

    // Start pulses on the request edge
    logic                  start_wr;
    logic                  start_rd;
    logic [reg_data_w-1:0] wdata;
    // Transfer end pulse
    logic                  done;
    // Last captured word
    logic [reg_data_w-1:0] rdata;

    modport front (
        output start_wr, start_rd, wdata,
        input  done, rdata
    );

    modport port (
        input  start_wr, start_rd, wdata,
        output done, rdata
    );

endinterface
